// ==== common/pcie_tx_pkg.sv ====
package pcie_tx_pkg;

   // framer states, wr_data repeats once per payload beat
   typedef enum logic [3:0] {
      idle,
      cpl_hdr,
      cpl_data0,
      cpl_data1,
      rd_hdr,
      rd_addr,
      wr_hdr,
      wr_addr,
      wr_data
   } tx_state_t;

   // packet kind offered by the selector
   typedef enum logic [1:0] {
      none,
      completion,
      read,
      write
   } pkt_kind_t;

   typedef struct packed {
      logic [31:0] dw2;   // completer header DW2
      logic [63:0] data;  // two data words, DW0 in the low half
   } cpl_req_t;

   typedef struct packed {
      logic [63:0] addr;
      logic [7:0]  tag;
   } rd_req_t;

   typedef struct packed {
      logic [63:0] addr;
   } wr_req_t;

   typedef struct packed {
      logic [63:0] data;
      logic        last;
      logic        one_dw;  // only the low DW of the beat is valid
   } tx_beat_t;

   // fixed packet lengths in DW
   localparam logic [9:0] RD_LEN_DW  = 10'd128;
   localparam logic [9:0] WR_LEN_DW  = 10'd32;
   localparam logic [9:0] CPL_LEN_DW = 10'd2;
   localparam int         WR_BEATS   = 16;

   // fmt and type byte of header DW0
   localparam logic [7:0] FT_CPLD  = 8'h4A;
   localparam logic [7:0] FT_MRD32 = 8'h00;
   localparam logic [7:0] FT_MRD64 = 8'h20;
   localparam logic [7:0] FT_MWR32 = 8'h40;
   localparam logic [7:0] FT_MWR64 = 8'h60;

   localparam logic [7:0]  BYTE_EN        = 8'hFF;  // last and first DW byte enables
   localparam logic [11:0] CPL_BYTE_COUNT = 12'd8;

   // header DW0 with TC, attributes and TD all zero
   function automatic logic [31:0] hdr_dw0(input logic [7:0] fmt_type, input logic [9:0] len);
      hdr_dw0 = {fmt_type, 14'd0, len};
   endfunction

   // host little endian word to PCIe byte order
   function automatic logic [31:0] dw_swap(input logic [31:0] x);
      dw_swap = {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

endpackage

// ==== pcie_tx/tlp_request_select.sv ====
`timescale 1ns/1ps

module tlp_request_select
   import pcie_tx_pkg::*;
(
   input  logic      clock,
   input  logic      reset,
   input  logic      cpl_done,
   input  cpl_req_t  cpl_req,
   input  logic      rd_valid,
   input  logic      wr_valid,
   input  logic      pkt_start,
   input  logic      pkt_done,
   input  pkt_kind_t done_kind,
   output pkt_kind_t next_kind,
   output cpl_req_t  cpl_held,
   output logic      rd_ready,
   output logic      wr_ready
);

   logic      cpl_pending;
   cpl_req_t  cpl_pend_data;  // waiting completion, not yet started
   pkt_kind_t finishing;

   assign finishing = pkt_done ? done_kind : none;

   // the kind that is just finishing is never offered again at once:
   // completions so they cannot starve the rest, read and write because
   // the source only drops its valid after the ready strobe
   always_comb
   begin
      if (cpl_pending && finishing != completion)
         next_kind = completion;
      else if (rd_valid && finishing != read)
         next_kind = read;
      else if (wr_valid && finishing != write)
         next_kind = write;
      else
         next_kind = none;
   end

   assign rd_ready = pkt_done && done_kind == read;
   assign wr_ready = pkt_done && done_kind == write;

   always_ff @(posedge clock)
   begin
      if (reset)
         cpl_pending <= 1'b0;
      else if (cpl_done)
         cpl_pending <= 1'b1;  // new one wins over a finishing one
      else if (pkt_done && done_kind == completion)
         cpl_pending <= 1'b0;
   end

   always_ff @(posedge clock)
   begin
      if (cpl_done)
         cpl_pend_data <= cpl_req;
      // frozen copy for the packet in flight
      if (pkt_start && next_kind == completion)
         cpl_held <= cpl_pend_data;
   end

endmodule

// ==== pcie_tx/tlp_payload_ram.sv ====
`timescale 1ns/1ps

module tlp_payload_ram
#(
   parameter int RAM_ADDR_W = 9
)
(
   input  logic                  clock,
   input  logic                  ram_write,
   input  logic [RAM_ADDR_W-1:0] ram_addr,
   input  logic [63:0]           ram_data,
   input  logic [RAM_ADDR_W-1:0] rd_index,
   input  logic                  advance,
   output logic [63:0]           q1,
   output logic [63:0]           q2
);

   logic [63:0] mem [0:(1 << RAM_ADDR_W)-1];
   logic [63:0] q0;

   // host side fill
   always_ff @(posedge clock)
   begin
      if (ram_write)
         mem[ram_addr] <= ram_data;
   end

   // read pipeline moves in step with the output beat
   // q1 and q2 let the framer straddle two words behind a 3-DW header
   always_ff @(posedge clock)
   begin
      if (advance)
      begin
         q0 <= mem[rd_index];
         q1 <= q0;
         q2 <= q1;
      end
   end

endmodule

// ==== pcie_tx/tlp_framer.sv ====
`timescale 1ns/1ps

module tlp_framer
   import pcie_tx_pkg::*;
#(
   parameter int RAM_ADDR_W = 9
)
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic [15:0]           pcie_id,
   input  pkt_kind_t             next_kind,
   input  cpl_req_t              cpl_held,
   input  rd_req_t               rd_req,
   input  wr_req_t               wr_req,
   input  logic [63:0]           q1,
   input  logic [63:0]           q2,
   input  logic                  tx_ready,
   output logic                  pkt_start,
   output logic                  pkt_done,
   output pkt_kind_t             done_kind,
   output logic [RAM_ADDR_W-1:0] rd_index,
   output logic                  advance,
   output tx_beat_t              tx_beat,
   output logic                  tx_valid
);

   tx_state_t  state;
   logic [3:0] beat_cnt;    // payload beat within a write
   logic       wr_is_32_q;
   logic       rd_is_32;
   logic       last_state;
   logic [3:0] word_cnt;    // RAM word requested this beat
   tx_beat_t   beat_next;

   assign advance  = tx_ready | ~tx_valid;
   assign rd_is_32 = rd_req.addr[63:32] == 32'h0;

   assign last_state = (state == cpl_data1) || (state == rd_addr) ||
                       (state == wr_data && beat_cnt == 4'(WR_BEATS - 1));

   always_comb
   begin
      case (state)
         cpl_hdr, cpl_data0, cpl_data1: done_kind = completion;
         rd_hdr, rd_addr:               done_kind = read;
         wr_hdr, wr_addr, wr_data:      done_kind = write;
         default:                       done_kind = none;
      endcase
   end

   assign pkt_done  = advance && last_state;
   assign pkt_start = advance && (state == idle || last_state) && next_kind != none;

   // word 0 is fetched by the beat before wr_hdr, hence the lead of three
   always_comb
   begin
      case (state)
         wr_hdr:  word_cnt = 4'd1;
         wr_addr: word_cnt = 4'd2;
         wr_data: word_cnt = (beat_cnt < 4'(WR_BEATS - 3)) ? beat_cnt + 4'd3 : 4'd0;
         default: word_cnt = 4'd0;
      endcase
   end

   assign rd_index = {wr_req.addr[7 +: RAM_ADDR_W-4], word_cnt};

   always_comb
   begin
      beat_next = '0;
      case (state)
         cpl_hdr:
            beat_next.data = {pcie_id, 4'h0, CPL_BYTE_COUNT, hdr_dw0(FT_CPLD, CPL_LEN_DW)};
         cpl_data0:
            beat_next.data = {dw_swap(cpl_held.data[31:0]), cpl_held.dw2};
         cpl_data1:
         begin
            beat_next.data   = {32'h0, dw_swap(cpl_held.data[63:32])};
            beat_next.last   = 1'b1;
            beat_next.one_dw = 1'b1;  // 3-DW header plus 2 DW is always odd
         end
         rd_hdr:
            beat_next.data = {pcie_id, rd_req.tag, BYTE_EN,
                              hdr_dw0(rd_is_32 ? FT_MRD32 : FT_MRD64, RD_LEN_DW)};
         rd_addr:
         begin
            if (rd_is_32)
               beat_next.data = {32'h0, rd_req.addr[31:0]};
            else
               beat_next.data = {rd_req.addr[31:0], rd_req.addr[63:32]};
            beat_next.last   = 1'b1;
            beat_next.one_dw = rd_is_32;
         end
         wr_hdr:
            beat_next.data = {pcie_id, 8'h00, BYTE_EN,
                              hdr_dw0(wr_is_32_q ? FT_MWR32 : FT_MWR64, WR_LEN_DW)};
         wr_addr:
         begin
            if (wr_is_32_q)
               beat_next.data = {dw_swap(q1[31:0]), wr_req.addr[31:0]};  // first DW rides along
            else
               beat_next.data = {wr_req.addr[31:0], wr_req.addr[63:32]};
         end
         wr_data:
         begin
            // 3-DW form is shifted by one DW across RAM words
            if (!wr_is_32_q)
               beat_next.data = {dw_swap(q2[63:32]), dw_swap(q2[31:0])};
            else if (last_state)
               beat_next.data = {32'h0, dw_swap(q2[63:32])};
            else
               beat_next.data = {dw_swap(q1[31:0]), dw_swap(q2[63:32])};
            beat_next.last   = last_state;
            beat_next.one_dw = last_state && wr_is_32_q;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         state    <= idle;
         beat_cnt <= 4'd0;
         tx_valid <= 1'b0;
      end
      else if (advance)
      begin
         tx_valid <= state != idle;
         if (state == idle || last_state)
         begin
            case (next_kind)
               completion: state <= cpl_hdr;
               read:       state <= rd_hdr;
               write:      state <= wr_hdr;
               default:    state <= idle;
            endcase
         end
         else
         begin
            case (state)
               cpl_hdr:   state <= cpl_data0;
               cpl_data0: state <= cpl_data1;
               rd_hdr:    state <= rd_addr;
               wr_hdr:    state <= wr_addr;
               wr_addr:   state <= wr_data;
               default:   state <= state;
            endcase
         end
         if (state == wr_data)
            beat_cnt <= beat_cnt + 4'd1;  // wraps back to zero after the last beat
      end
   end

   always_ff @(posedge clock)
   begin
      if (advance)
         tx_beat <= beat_next;
      if (pkt_start && next_kind == write)
         wr_is_32_q <= wr_req.addr[63:32] == 32'h0;
   end

endmodule

// ==== hw/pcie_tx_top.sv ====
`timescale 1ns/1ps

module pcie_tx_top
   import pcie_tx_pkg::*;
#(
   parameter int RAM_ADDR_W = 9
)
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic [15:0]           pcie_id,
   input  logic                  cpl_done,
   input  cpl_req_t              cpl_req,
   input  logic                  rd_valid,
   input  rd_req_t               rd_req,
   input  logic                  wr_valid,
   input  wr_req_t               wr_req,
   input  logic                  ram_write,
   input  logic [RAM_ADDR_W-1:0] ram_addr,
   input  logic [63:0]           ram_data,
   input  logic                  tx_ready,
   output logic                  rd_ready,
   output logic                  wr_ready,
   output tx_beat_t              tx_beat,
   output logic                  tx_valid
);

   pkt_kind_t             next_kind;
   pkt_kind_t             done_kind;
   cpl_req_t              cpl_held;
   logic                  pkt_start;
   logic                  pkt_done;
   logic [RAM_ADDR_W-1:0] rd_index;
   logic                  advance;
   logic [63:0]           q1;
   logic [63:0]           q2;

   tlp_request_select select
   (
      .clock     (clock),
      .reset     (reset),
      .cpl_done  (cpl_done),
      .cpl_req   (cpl_req),
      .rd_valid  (rd_valid),
      .wr_valid  (wr_valid),
      .pkt_start (pkt_start),
      .pkt_done  (pkt_done),
      .done_kind (done_kind),
      .next_kind (next_kind),
      .cpl_held  (cpl_held),
      .rd_ready  (rd_ready),
      .wr_ready  (wr_ready)
   );

   tlp_payload_ram #(.RAM_ADDR_W(RAM_ADDR_W)) payload_ram
   (
      .clock     (clock),
      .ram_write (ram_write),
      .ram_addr  (ram_addr),
      .ram_data  (ram_data),
      .rd_index  (rd_index),
      .advance   (advance),
      .q1        (q1),
      .q2        (q2)
   );

   tlp_framer #(.RAM_ADDR_W(RAM_ADDR_W)) framer
   (
      .clock     (clock),
      .reset     (reset),
      .pcie_id   (pcie_id),
      .next_kind (next_kind),
      .cpl_held  (cpl_held),
      .rd_req    (rd_req),
      .wr_req    (wr_req),
      .q1        (q1),
      .q2        (q2),
      .tx_ready  (tx_ready),
      .pkt_start (pkt_start),
      .pkt_done  (pkt_done),
      .done_kind (done_kind),
      .rd_index  (rd_index),
      .advance   (advance),
      .tx_beat   (tx_beat),
      .tx_valid  (tx_valid)
   );

endmodule

// ==== verif/pcie_tx_checker.sv ====
`timescale 1ns/1ps

module pcie_tx_checker
   import pcie_tx_pkg::*;
#(
   parameter int RAM_ADDR_W = 9
)
(
   input  logic                  clock,
   input  logic                  reset,
   input  logic [15:0]           pcie_id,
   input  logic                  cpl_done,
   input  cpl_req_t              cpl_req,
   input  logic                  rd_valid,
   input  rd_req_t               rd_req,
   input  logic                  rd_ready,
   input  logic                  wr_valid,
   input  wr_req_t               wr_req,
   input  logic                  wr_ready,
   input  logic                  ram_write,
   input  logic [RAM_ADDR_W-1:0] ram_addr,
   input  logic [63:0]           ram_data,
   input  logic                  tx_ready,
   input  tx_beat_t              tx_beat,
   input  logic                  tx_valid,
   output int                    error_count,
   output int                    beat_count,
   output int                    pkt_count,
   output int                    cpl_count
);

   logic [63:0] ram_model [0:(1 << RAM_ADDR_W)-1];
   tx_beat_t    exp_q[$];      // rest of the packet on the wire
   cpl_req_t    cpl_q[$];
   int          cpl_cyc[$];    // cycle each completion was posted
   pkt_kind_t   cur_kind;
   pkt_kind_t   prev_kind;
   string       cur_name;
   int          beat_idx;
   int          cycle;
   int          decide_cycle;  // cycle the framer picked the packet after the previous one
   int          rd_since;
   logic        have_prev;
   logic        rd_active;
   logic        wr_active;
   logic        strobe_given;  // ready strobe seen for the current packet
   logic        req_seen;
   logic        hold_valid;
   tx_beat_t    held_beat;

   initial
   begin
      error_count = 0;
      beat_count  = 0;
      pkt_count   = 0;
      cpl_count   = 0;
      cur_kind    = none;
   end

   function automatic logic [31:0] byte_reverse(input logic [31:0] x);
      byte_reverse = {x[7:0], x[15:8], x[23:16], x[31:24]};
   endfunction

   function automatic tx_beat_t make_beat(input logic [63:0] d, input logic l, input logic o);
      tx_beat_t b;
      b.data   = d;
      b.last   = l;
      b.one_dw = o;
      return b;
   endfunction

   task automatic fail(input string what);
      error_count++;
      $display("%0t: %s", $time, what);
   endtask

   // next packet is picked while the last beat of the previous one is built
   task automatic check_priority(input pkt_kind_t kind);
      if (!have_prev)
         return;
      if (kind != completion && prev_kind != completion && cpl_cyc.size() > 0 &&
          cpl_cyc[0] < decide_cycle)
         fail($sformatf("a pending completion was passed over by a %s packet", kind.name()));
      if (kind == write && prev_kind != read && rd_active && rd_since < decide_cycle)
         fail("a pending read was passed over by a write packet");
   endtask

   task automatic build_packet(input tx_beat_t hdr);
      logic [7:0]            ft;
      logic [63:0]           a;
      logic [RAM_ADDR_W-5:0] blk;
      logic [63:0]           w [0:15];
      logic [63:0]           d;
      logic                  is32;
      cpl_req_t              c;
      ft = hdr.data[31:24];
      if (ft == 8'h4A)
      begin
         cur_kind = completion;
         cur_name = "completion";
         if (cpl_q.size() == 0)
         begin
            fail("completion packet sent with no completion pending");
            return;
         end
         c = cpl_q.pop_front();
         cpl_cyc.delete(0);
         exp_q.push_back(make_beat({pcie_id, 4'h0, 12'd8, 8'h4A, 14'd0, 10'd2}, 0, 0));
         exp_q.push_back(make_beat({byte_reverse(c.data[31:0]), c.dw2}, 0, 0));
         exp_q.push_back(make_beat({32'h0, byte_reverse(c.data[63:32])}, 1, 1));
      end
      else if (ft == 8'h00 || ft == 8'h20)
      begin
         cur_kind = read;
         cur_name = "read";
         check_priority(read);
         if (!rd_active)
            fail("read packet sent with no read request pending");
         a    = rd_req.addr;
         is32 = a[63:32] == 32'h0;
         exp_q.push_back(make_beat({pcie_id, rd_req.tag, 8'hFF, is32 ? 8'h00 : 8'h20,
                                    14'd0, 10'd128}, 0, 0));
         if (is32)
            exp_q.push_back(make_beat({32'h0, a[31:0]}, 1, 1));
         else
            exp_q.push_back(make_beat({a[31:0], a[63:32]}, 1, 0));
      end
      else if (ft == 8'h40 || ft == 8'h60)
      begin
         cur_kind = write;
         cur_name = "write";
         check_priority(write);
         if (!wr_active)
            fail("write packet sent with no write request pending");
         a    = wr_req.addr;
         is32 = a[63:32] == 32'h0;
         blk  = a[7 +: RAM_ADDR_W-4];
         for (int i = 0; i < 16; i++)
            w[i] = ram_model[{blk, 4'(i)}];
         exp_q.push_back(make_beat({pcie_id, 8'h00, 8'hFF, is32 ? 8'h40 : 8'h60,
                                    14'd0, 10'd32}, 0, 0));
         if (is32)
            exp_q.push_back(make_beat({byte_reverse(w[0][31:0]), a[31:0]}, 0, 0));
         else
            exp_q.push_back(make_beat({a[31:0], a[63:32]}, 0, 0));
         for (int i = 0; i < 16; i++)
         begin
            if (!is32)
               d = {byte_reverse(w[i][63:32]), byte_reverse(w[i][31:0])};
            else if (i == 15)
               d = {32'h0, byte_reverse(w[15][63:32])};
            else
               d = {byte_reverse(w[i+1][31:0]), byte_reverse(w[i][63:32])};  // one DW shift
            exp_q.push_back(make_beat(d, i == 15, i == 15 && is32));
         end
      end
      else
      begin
         cur_kind = none;
         fail($sformatf("header beat with unknown format and type %h", ft));
         return;
      end
      strobe_given = 1'b0;
      beat_idx     = 0;
      have_prev    = 1'b1;
      prev_kind    = cur_kind;
   endtask

   task automatic take_beat(input tx_beat_t b);
      tx_beat_t e;
      if (exp_q.size() == 0)
         build_packet(b);
      if (exp_q.size() == 0)
         return;
      e = exp_q.pop_front();
      beat_count++;
      if (b !== e)
      begin
         error_count++;
         $display("ERROR %s beat %0d expected %h actual %h", cur_name, beat_idx, e, b);
      end
      beat_idx++;
      if (exp_q.size() == 1)
         decide_cycle = cycle;  // last beat is being built now
      if (exp_q.size() == 0)
      begin
         pkt_count++;
         if (cur_kind == completion)
            cpl_count++;
         else if (!strobe_given)
            fail($sformatf("%s packet ended without its ready strobe", cur_name));
      end
   endtask

   // sampled mid cycle, inputs and outputs are both settled here
   always @(negedge clock)
   begin
      if (reset)
      begin
         if (tx_valid || rd_ready || wr_ready)
            fail("tx_valid or a ready strobe is high during reset");
         cycle      = 0;
         have_prev  = 1'b0;
         rd_active  = 1'b0;
         wr_active  = 1'b0;
         hold_valid = 1'b0;
         req_seen   = 1'b0;
         exp_q.delete();
         cpl_q.delete();
         cpl_cyc.delete();
      end
      else
      begin
         cycle++;
         if (!req_seen && (tx_valid || rd_ready || wr_ready))
            fail("outputs became active before any request");
         if (cpl_done || rd_valid || wr_valid)
            req_seen = 1'b1;
         if (cpl_done)
         begin
            cpl_q.push_back(cpl_req);
            cpl_cyc.push_back(cycle);
         end
         if (rd_valid && !rd_active)
         begin
            rd_active = 1'b1;
            rd_since  = cycle;
         end
         if (wr_valid)
            wr_active = 1'b1;
         if (hold_valid && (!tx_valid || tx_beat !== held_beat))
            fail("output beat changed while stalled by tx_ready");
         hold_valid = tx_valid && !tx_ready;
         held_beat  = tx_beat;
         if (tx_valid && tx_ready)
            take_beat(tx_beat);
         if (rd_ready)
         begin
            if (cur_kind != read || strobe_given)
               fail("rd_ready pulsed outside of its read packet");
            strobe_given = 1'b1;
            rd_active    = 1'b0;
         end
         if (wr_ready)
         begin
            if (cur_kind != write || strobe_given)
               fail("wr_ready pulsed outside of its write packet");
            strobe_given = 1'b1;
            wr_active    = 1'b0;
         end
         if (ram_write)
            ram_model[ram_addr] = ram_data;
      end
   end

endmodule

// ==== verif/pcie_tx_tb.sv ====
`timescale 1ns/1ps

module pcie_tx_tb
   import pcie_tx_pkg::*;
();

   localparam int RAM_ADDR_W = 9;
   localparam int PERIOD     = 100;
   localparam int NUM_REQ    = 80;
   localparam int WATCHDOG_CYCLES = 16 + (1 << RAM_ADDR_W) + NUM_REQ * 40 + 400;

   logic                  clock;
   logic                  reset;
   logic [15:0]           pcie_id;
   logic                  cpl_done;
   cpl_req_t              cpl_req;
   logic                  rd_valid;
   rd_req_t               rd_req;
   logic                  wr_valid;
   wr_req_t               wr_req;
   logic                  ram_write;
   logic [RAM_ADDR_W-1:0] ram_addr;
   logic [63:0]           ram_data;
   logic                  tx_ready;
   logic                  rd_ready;
   logic                  wr_ready;
   tx_beat_t              tx_beat;
   logic                  tx_valid;

   int          chk_errors;
   int          chk_beats;
   int          chk_pkts;
   int          chk_cpls;
   int          cpl_issued;
   int          rd_issued;
   int          wr_issued;
   int          rd_acks;
   int          wr_acks;
   logic [31:0] seed;
   logic [31:0] ready_seed;  // own stream for back-pressure

   pcie_tx_top #(.RAM_ADDR_W(RAM_ADDR_W)) uut
   (
      .clock     (clock),
      .reset     (reset),
      .pcie_id   (pcie_id),
      .cpl_done  (cpl_done),
      .cpl_req   (cpl_req),
      .rd_valid  (rd_valid),
      .rd_req    (rd_req),
      .wr_valid  (wr_valid),
      .wr_req    (wr_req),
      .ram_write (ram_write),
      .ram_addr  (ram_addr),
      .ram_data  (ram_data),
      .tx_ready  (tx_ready),
      .rd_ready  (rd_ready),
      .wr_ready  (wr_ready),
      .tx_beat   (tx_beat),
      .tx_valid  (tx_valid)
   );

   pcie_tx_checker #(.RAM_ADDR_W(RAM_ADDR_W)) chk
   (
      .clock       (clock),
      .reset       (reset),
      .pcie_id     (pcie_id),
      .cpl_done    (cpl_done),
      .cpl_req     (cpl_req),
      .rd_valid    (rd_valid),
      .rd_req      (rd_req),
      .rd_ready    (rd_ready),
      .wr_valid    (wr_valid),
      .wr_req      (wr_req),
      .wr_ready    (wr_ready),
      .ram_write   (ram_write),
      .ram_addr    (ram_addr),
      .ram_data    (ram_data),
      .tx_ready    (tx_ready),
      .tx_beat     (tx_beat),
      .tx_valid    (tx_valid),
      .error_count (chk_errors),
      .beat_count  (chk_beats),
      .pkt_count   (chk_pkts),
      .cpl_count   (chk_cpls)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      lcg_next = s * 32'd1103515245 + 32'd12345;
   endfunction

   function logic [15:0] rand16();
      seed = lcg_next(seed);
      return seed[30:15];  // low bits of an LCG are weak
   endfunction

   function logic [63:0] rand64();
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < 4; i++)
         r = {r[47:0], rand16()};
      return r;
   endfunction

   // half of the addresses get zero upper bits and a 3-DW header
   function logic [63:0] rand_addr();
      logic [63:0] a;
      a = rand64();
      if (rand16() % 2 == 0)
         a[63:32] = 32'h0;
      a[1:0] = 2'b00;
      return a;
   endfunction

   initial
   begin
      clock = 1'b0;
      forever
         #(PERIOD / 2) clock = ~clock;
   end

   always @(negedge clock)
   begin
      if (!reset && rd_ready)
         rd_acks++;
      if (!reset && wr_ready)
         wr_acks++;
   end

   // one clock, then inputs move 10 ns after the edge
   task automatic step();
      @(posedge clock);
      #10;
      cpl_done   = 1'b0;
      ram_write  = 1'b0;
      ready_seed = lcg_next(ready_seed);
      tx_ready   = (ready_seed[30:16] % 10) >= 3;  // low about 30% of cycles
      if (rd_valid && rd_acks == rd_issued)
         rd_valid = 1'b0;
      if (wr_valid && wr_acks == wr_issued)
         wr_valid = 1'b0;
   endtask

   task automatic fill_ram();
      for (int a = 0; a < (1 << RAM_ADDR_W); a++)
      begin
         step();
         ram_write = 1'b1;
         ram_addr  = a[RAM_ADDR_W-1:0];
         ram_data  = rand64();
      end
      step();
   endtask

   task automatic send_completion();
      while (cpl_issued != chk_cpls)
         step();  // only one completion in flight
      cpl_done     = 1'b1;
      cpl_req.dw2  = {rand16(), rand16()};
      cpl_req.data = rand64();
      cpl_issued++;
   endtask

   task automatic send_read();
      while (rd_valid)
         step();
      rd_req.addr = rand_addr();
      rd_req.tag  = 8'(rand16());
      rd_valid    = 1'b1;
      rd_issued++;
   endtask

   task automatic send_write();
      while (wr_valid)
         step();
      wr_req.addr = rand_addr();
      // refresh part of the target block while no write is running
      for (int k = 0; k < 4; k++)
      begin
         step();
         ram_write = 1'b1;
         ram_addr  = {wr_req.addr[7 +: RAM_ADDR_W-4], 4'(rand16() % 16)};
         ram_data  = rand64();
      end
      step();
      wr_valid = 1'b1;
      wr_issued++;
   endtask

   initial
   begin
      #(WATCHDOG_CYCLES * PERIOD);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      seed       = 32'd60766;
      ready_seed = ~32'd60766;
      reset      = 1'b1;
      pcie_id    = 16'h0A30;
      cpl_done   = 1'b0;
      cpl_req    = '0;
      rd_valid   = 1'b0;
      rd_req     = '0;
      wr_valid   = 1'b0;
      wr_req     = '0;
      ram_write  = 1'b0;
      ram_addr   = '0;
      ram_data   = '0;
      tx_ready   = 1'b0;
      cpl_issued = 0;
      rd_issued  = 0;
      wr_issued  = 0;
      rd_acks    = 0;
      wr_acks    = 0;
      repeat (16)
         step();
      reset = 1'b0;
      fill_ram();
      for (int n = 0; n < NUM_REQ; n++)
      begin
         case (rand16() % 3)
            0:       send_completion();
            1:       send_read();
            default: send_write();
         endcase
         repeat (rand16() % 4)
            step();
      end
      while (rd_valid || wr_valid || chk_pkts != cpl_issued + rd_issued + wr_issued)
         step();
      repeat (20)
         step();
      $display("errors %0d, beats checked %0d, packets %0d of %0d",
               chk_errors, chk_beats, chk_pkts, NUM_REQ);
      if (chk_errors == 0 && chk_pkts == NUM_REQ)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== sim.f ====
common/pcie_tx_pkg.sv
pcie_tx/tlp_request_select.sv
pcie_tx/tlp_payload_ram.sv
pcie_tx/tlp_framer.sv
hw/pcie_tx_top.sv
verif/pcie_tx_checker.sv
verif/pcie_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := pcie_tx_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf $(OBJ_DIR)
